// ==== include/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// bus widths, the byte-lane logic assumes a 32-bit word
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_BE_W   4  // one enable per byte lane

`endif

// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

  // access size as encoded by the decoder, 2'b11 behaves as a byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  typedef logic [1:0] lsu_offset_t; // byte position inside a word

  // transaction FSM
  typedef enum logic [2:0] {
    LS_IDLE,
    LS_WAIT_GNT_MIS,              // first part of a split access waits for grant
    LS_WAIT_RVALID_MIS,           // first part granted, second part requested
    LS_WAIT_GNT,                  // single access or last part waits for grant
    LS_WAIT_RVALID_MIS_GNTS_DONE  // both parts granted, first rvalid outstanding
  } ls_fsm_e;

endpackage

// ==== hw/lsu_req_if.sv ====
`timescale 1ns/1ps

// request attributes from the execute stage plus the controller strobes
interface lsu_req_if
  import lsu_pkg::*;
();

  lsu_type_e   data_type;         // access size
  lsu_offset_t offset;            // addr[1:0] of the current request
  logic        sign_ext;          // sign extend loaded halfwords and bytes
  logic        we;                // store when high

  logic        ctrl_update;       // capture the load attributes
  logic        rdata_update;      // capture first half of a split load
  logic        handle_misaligned; // second part of a split access in progress

  modport src (
    output data_type, offset, sign_ext, we
  );

  modport ctrl (
    input  data_type, offset, we,
    output ctrl_update, rdata_update, handle_misaligned
  );

  modport wdp (
    input data_type, offset, handle_misaligned
  );

  modport rdp (
    input data_type, offset, sign_ext, ctrl_update, rdata_update
  );

endinterface

// ==== hw/lsu_ctrl.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   lsu_req_i,       // access request from execute
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,      // valid with rvalid
  input  logic [`LSU_ADDR_W-1:0] addr_i,          // unaligned address from the adder

  lsu_req_if.ctrl                req,

  output logic                   data_req_o,
  output logic                   addr_incr_req_o, // execute must present addr + 4
  output logic                   lsu_req_done_o,
  output logic                   lsu_resp_valid_o,
  output logic                   lsu_rdata_valid_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o,
  output logic [`LSU_ADDR_W-1:0] addr_last_o      // trap value / first failing address
);

  ls_fsm_e ls_fsm_cs, ls_fsm_ns;

  logic split_access;          // access needs two bus requests
  logic handle_mis_q, handle_mis_d;
  logic lsu_err_q, lsu_err_d;  // error seen on the first part
  logic data_we_q;             // kind of the access in flight
  logic addr_update;
  logic ctrl_update;
  logic rdata_update;
  logic any_err;

  logic [`LSU_ADDR_W-1:0] addr_last_q;

  // a word off its boundary, or a halfword starting in the top lane
  assign split_access = ((req.data_type == LSU_WORD) && (req.offset != 2'b00)) ||
                        ((req.data_type == LSU_HALF) && (req.offset == 2'b11));

  //////////////////////////////////////////////////////////////////////
  // transaction FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns       = ls_fsm_cs;
    handle_mis_d    = handle_mis_q;
    lsu_err_d       = lsu_err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update     = 1'b0;
    rdata_update    = 1'b0;

    unique case (ls_fsm_cs)
      LS_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0; // fresh access
          if (data_gnt_i) begin
            ctrl_update  = 1'b1;
            addr_update  = 1'b1;
            handle_mis_d = split_access;
            ls_fsm_ns    = split_access ? LS_WAIT_RVALID_MIS : LS_IDLE;
          end else begin
            ls_fsm_ns    = split_access ? LS_WAIT_GNT_MIS : LS_WAIT_GNT;
          end
        end
      end

      LS_WAIT_GNT_MIS: begin
        data_req_o = 1'b1; // hold first part until granted
        if (data_gnt_i) begin
          ctrl_update  = 1'b1;
          addr_update  = 1'b1;
          handle_mis_d = 1'b1;
          ls_fsm_ns    = LS_WAIT_RVALID_MIS;
        end
      end

      LS_WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1; // second part goes out right away
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d    = data_err_i;                // first part status
          rdata_update = ~data_we_q;                // keep upper bytes of a load
          addr_update  = data_gnt_i & ~data_err_i;  // keep failing address
          handle_mis_d = ~data_gnt_i;
          ls_fsm_ns    = data_gnt_i ? LS_IDLE : LS_WAIT_GNT;
        end else if (data_gnt_i) begin
          // second grant before first response
          handle_mis_d = 1'b0;
          ls_fsm_ns    = LS_WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      LS_WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = handle_mis_q; // only when this is the second part
        if (data_gnt_i) begin
          ctrl_update  = 1'b1;
          addr_update  = ~lsu_err_q;
          handle_mis_d = 1'b0;
          ls_fsm_ns    = LS_IDLE;
        end
      end

      LS_WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1; // keeps addr + 4 valid for addr_last
        if (data_rvalid_i) begin
          lsu_err_d    = data_err_i;
          addr_update  = ~data_err_i;
          rdata_update = ~data_we_q;
          ls_fsm_ns    = LS_IDLE; // second rvalid arrives in idle
        end
      end

      default: ls_fsm_ns = LS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs    <= LS_IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      ls_fsm_cs    <= ls_fsm_ns;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  // access kind, latched with the other attributes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_we_q <= 1'b0;
    end else if (ctrl_update) begin
      data_we_q <= req.we;
    end
  end

  // last address for mtval, frozen after a first-part error
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign req.ctrl_update       = ctrl_update;
  assign req.rdata_update      = rdata_update;
  assign req.handle_misaligned = handle_mis_q;

  assign lsu_req_done_o    = (lsu_req_i | (ls_fsm_cs != LS_IDLE)) & (ls_fsm_ns == LS_IDLE);

  assign any_err           = lsu_err_q | data_err_i;  // either part failed
  assign lsu_resp_valid_o  = data_rvalid_i & (ls_fsm_cs == LS_IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~any_err & ~data_we_q;
  assign load_err_o        = lsu_resp_valid_o & any_err & ~data_we_q;
  assign store_err_o       = lsu_resp_valid_o & any_err &  data_we_q;

  assign busy_o      = (ls_fsm_cs != LS_IDLE);
  assign addr_last_o = addr_last_q;

endmodule

// ==== hw/lsu_wdata_align.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_wdata_align
  import lsu_pkg::*;
(
  lsu_req_if.wdp                 req,

  input  logic [`LSU_DATA_W-1:0] wdata_i, // store data, lsb aligned
  output logic [`LSU_BE_W-1:0]   be_o,    // lanes touched by this bus request
  output logic [`LSU_DATA_W-1:0] wdata_o  // data rotated into its lanes
);

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req.data_type)
      LSU_WORD: begin
        if (!req.handle_misaligned) begin
          be_o = 4'b1111 << req.offset;     // lanes k..3
        end else begin
          be_o = ~(4'b1111 << req.offset);  // lanes 0..k-1 of next word
        end
      end
      LSU_HALF: begin
        if (!req.handle_misaligned) begin
          be_o = 4'b0011 << req.offset;     // lane 4 drops out at offset 3
        end else begin
          be_o = 4'b0001;
        end
      end
      default: be_o = 4'b0001 << req.offset; // byte, also code 2'b11
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // write data rotation
  //////////////////////////////////////////////////////////////////////

  // rotate left by offset bytes, same rotation serves both parts
  always_comb begin
    unique case (req.offset)
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      2'b11:   wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
      default: wdata_o = wdata_i;
    endcase
  end

endmodule

// ==== hw/lsu_rdata_align.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_rdata_align
  import lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`LSU_DATA_W-1:0] rdata_i, // raw bus read data

  lsu_req_if.rdp                 req,

  output logic [`LSU_DATA_W-1:0] rdata_o  // aligned and extended load data
);

  lsu_offset_t offset_q;
  lsu_type_e   type_q;
  logic        sign_ext_q;
  logic [23:0] upper_q;      // bytes 3..1 of the first part

  logic [55:0] joined;       // second part above first part upper bytes
  logic [1:0]  word_sel;     // byte index of the word window in joined
  logic [31:0] rdata_w;
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;
  logic        sign_bit;

  //////////////////////////////////////////////////////////////////////
  // captured attributes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (req.ctrl_update) begin
      offset_q   <= req.offset;
      type_q     <= req.data_type;
      sign_ext_q <= req.sign_ext;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.rdata_update) begin
      upper_q <= rdata_i[31:8]; // byte 0 never belongs to a split load
    end
  end

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  assign joined   = {rdata_i, upper_q};
  assign word_sel = offset_q - 2'd1; // offset 0 wraps to the plain bus word
  assign rdata_w  = joined[{word_sel, 3'b000} +: 32];

  always_comb begin
    if (offset_q == 2'b11) begin
      half_raw = {rdata_i[7:0], upper_q[23:16]}; // halfword across the boundary
    end else begin
      half_raw = rdata_i[{offset_q, 3'b000} +: 16];
    end
  end

  assign byte_raw = rdata_i[{offset_q, 3'b000} +: 8];

  //////////////////////////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sign_bit = 1'b0;
    unique case (type_q)
      LSU_WORD: begin
        rdata_o = rdata_w;
      end
      LSU_HALF: begin
        sign_bit = sign_ext_q & half_raw[15];
        rdata_o  = {{16{sign_bit}}, half_raw};
      end
      default: begin // byte
        sign_bit = sign_ext_q & byte_raw[7];
        rdata_o  = {{24{sign_bit}}, byte_raw};
      end
    endcase
  end

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  output logic [`LSU_ADDR_W-1:0] data_addr_o,      // always word aligned
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,

  // execute stage side
  input  logic                   lsu_we_i,
  input  lsu_type_e              lsu_type_i,
  input  logic [`LSU_DATA_W-1:0] lsu_wdata_i,
  input  logic                   lsu_sign_ext_i,
  input  logic                   lsu_req_i,
  input  logic [`LSU_ADDR_W-1:0] adder_result_ex_i, // byte address from the ALU

  output logic [`LSU_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_rdata_valid_o,
  output logic                   addr_incr_req_o,
  output logic [`LSU_ADDR_W-1:0] addr_last_o,
  output logic                   lsu_req_done_o,
  output logic                   lsu_resp_valid_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o
);

  lsu_req_if u_req_if ();

  // attributes straight from execute
  assign u_req_if.data_type = lsu_type_i;
  assign u_req_if.offset    = adder_result_ex_i[1:0];
  assign u_req_if.sign_ext  = lsu_sign_ext_i;
  assign u_req_if.we        = lsu_we_i;

  assign data_addr_o = {adder_result_ex_i[`LSU_ADDR_W-1:2], 2'b00};
  assign data_we_o   = lsu_we_i;

  lsu_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .addr_i            (adder_result_ex_i),
    .req               (u_req_if.ctrl),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o),
    .addr_last_o       (addr_last_o)
  );

  lsu_wdata_align u_wdata_align (
    .req     (u_req_if.wdp),
    .wdata_i (lsu_wdata_i),
    .be_o    (data_be_o),
    .wdata_o (data_wdata_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rdata_i (data_rdata_i),
    .req     (u_req_if.rdp),
    .rdata_o (lsu_rdata_o)
  );

endmodule

// ==== verification/lsu_props.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

// bus and FSM properties bound into every lsu_ctrl instance
module lsu_props
  import lsu_pkg::*;
(
  input logic                   clk_i,
  input logic                   rst_ni,
  input ls_fsm_e                ls_fsm_cs,
  input logic                   data_req_o,
  input logic                   data_gnt_i,
  input logic [`LSU_ADDR_W-1:0] addr_i,     // unaligned byte address from execute
  input logic                   load_err_o,
  input logic                   store_err_o
);

  int n_fail = 0; // failed property evaluations

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ls_fsm_cs inside {LS_IDLE, LS_WAIT_GNT_MIS, LS_WAIT_RVALID_MIS, LS_WAIT_GNT,
                      LS_WAIT_RVALID_MIS_GNTS_DONE})
    else begin
      n_fail++;
      $error("controller state left the legal encodings");
    end

  // word address driven on the bus must be known
  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> !$isunknown(addr_i[`LSU_ADDR_W-1:2]))
    else begin
      n_fail++;
      $error("bus word address unknown during a request");
    end

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o)
    else begin
      n_fail++;
      $error("request dropped before its grant");
    end

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> $stable(addr_i[`LSU_ADDR_W-1:2]))
    else begin
      n_fail++;
      $error("bus address moved while waiting for grant");
    end

  a_err_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_err_o && store_err_o))
    else begin
      n_fail++;
      $error("load and store error raised together");
    end

endmodule

// ==== verification/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam int N_TESTS = 5;
  localparam int WATCHDOG_CYCLES = N_TESTS * 200;

  logic clk_i = 1'b0;
  logic rst_n = 1'b0;

  // bus side driven by the memory model
  logic                   data_gnt    = 1'b0;
  logic                   data_rvalid = 1'b0;
  logic                   data_err    = 1'b0;
  logic [`LSU_DATA_W-1:0] data_rdata  = '0;
  logic                   data_req_o, data_we_o;
  logic [`LSU_ADDR_W-1:0] data_addr_o;
  logic [`LSU_BE_W-1:0]   data_be_o;
  logic [`LSU_DATA_W-1:0] data_wdata_o;

  // execute stage side
  logic                   lsu_we       = 1'b0;
  lsu_type_e              lsu_type     = LSU_WORD;
  logic [`LSU_DATA_W-1:0] lsu_wdata    = '0;
  logic                   lsu_sign_ext = 1'b0;
  logic                   lsu_req      = 1'b0;
  logic [`LSU_ADDR_W-1:0] base_addr    = '0;   // address of the first part
  logic [`LSU_ADDR_W-1:0] adder_result;
  logic [`LSU_DATA_W-1:0] lsu_rdata_o;
  logic [`LSU_ADDR_W-1:0] addr_last_o;
  logic lsu_rdata_valid_o, addr_incr_req_o, lsu_req_done_o, lsu_resp_valid_o;
  logic load_err_o, store_err_o, busy_o;

  logic [7:0]             mem [0:1023];  // byte addressed
  logic [`LSU_ADDR_W-1:0] bad_q [$];     // word addresses answering with an error
  logic [`LSU_BE_W-1:0]   be_q [$];      // enables of each granted request
  int                     n_incr;        // cycles with addr_incr_req_o high
  int                     gnt_wait;
  int                     n_checks = 0;
  int                     n_errors = 0;

  always #4 clk_i = ~clk_i;

  // second part of a split access sits one word higher
  assign adder_result = addr_incr_req_o ? base_addr + 32'd4 : base_addr;

  lsu_top u_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_n),
    .data_req_o        (data_req_o),
    .data_gnt_i        (data_gnt),
    .data_rvalid_i     (data_rvalid),
    .data_err_i        (data_err),
    .data_addr_o       (data_addr_o),
    .data_we_o         (data_we_o),
    .data_be_o         (data_be_o),
    .data_wdata_o      (data_wdata_o),
    .data_rdata_i      (data_rdata),
    .lsu_we_i          (lsu_we),
    .lsu_type_i        (lsu_type),
    .lsu_wdata_i       (lsu_wdata),
    .lsu_sign_ext_i    (lsu_sign_ext),
    .lsu_req_i         (lsu_req),
    .adder_result_ex_i (adder_result),
    .lsu_rdata_o       (lsu_rdata_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .addr_last_o       (addr_last_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  bind lsu_ctrl lsu_props u_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ls_fsm_cs   (ls_fsm_cs),
    .data_req_o  (data_req_o),
    .data_gnt_i  (data_gnt_i),
    .addr_i      (addr_i),
    .load_err_o  (load_err_o),
    .store_err_o (store_err_o)
  );

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  function automatic logic is_bad(logic [`LSU_ADDR_W-1:0] a);
    for (int i = 0; i < bad_q.size(); i++) begin
      if (bad_q[i][`LSU_ADDR_W-1:2] == a[`LSU_ADDR_W-1:2]) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic [31:0] mem_word(logic [`LSU_ADDR_W-1:0] a);
    return {mem[a[9:0] + 3], mem[a[9:0] + 2], mem[a[9:0] + 1], mem[a[9:0]]};
  endfunction

  // rvalid one cycle after each grant with a grant delay of 0..2 cycles
  always @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      data_gnt    <= 1'b0;
      data_rvalid <= 1'b0;
      data_err    <= 1'b0;
      gnt_wait    = 0;
    end else begin
      data_rvalid <= 1'b0;
      data_err    <= 1'b0;
      if (addr_incr_req_o) n_incr++;
      if (data_req_o && data_gnt) begin
        be_q.push_back(data_be_o);
        data_rvalid <= 1'b1;
        if (is_bad(data_addr_o)) begin
          data_err <= 1'b1;
        end else if (data_we_o) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be_o[b]) mem[data_addr_o[9:0] + b] = data_wdata_o[8*b +: 8];
          end
        end else begin
          data_rdata <= mem_word(data_addr_o);
        end
        gnt_wait = $urandom_range(2, 0);
      end else if (data_req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
      data_gnt <= (gnt_wait == 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_data(string what, logic [`LSU_DATA_W-1:0] got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(string what, logic [`LSU_ADDR_W-1:0] got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_type(string what, lsu_type_e got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED @%0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(string what, logic got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // access helpers
  //////////////////////////////////////////////////////////////////////

  // expected load result from the size and extension rules
  function automatic logic [31:0] ext_expect(lsu_type_e t, logic [31:0] v, logic sx);
    if (t == LSU_BYTE) return {{24{sx & v[7]}}, v[7:0]};
    if (t == LSU_HALF) return {{16{sx & v[15]}}, v[15:0]};
    return v;
  endfunction

  task automatic do_access(input logic we, input lsu_type_e t, input logic [31:0] addr,
                           input logic [31:0] wd, input logic sx, output logic [31:0] rd,
                           output logic v, output logic le, output logic se);
    be_q.delete();
    n_incr = 0;
    @(posedge clk_i);
    base_addr    <= addr;
    lsu_we       <= we;
    lsu_type     <= t;
    lsu_wdata    <= wd;
    lsu_sign_ext <= sx;
    lsu_req      <= 1'b1;
    do @(posedge clk_i); while (!lsu_req_done_o); // last grant seen
    lsu_req <= 1'b0;
    do @(posedge clk_i); while (!lsu_resp_valid_o);
    rd = lsu_rdata_o;
    v  = lsu_rdata_valid_o;
    le = load_err_o;
    se = store_err_o;
    check_type("captured size", u_dut.u_rdata_align.type_q, t);
  endtask

  task automatic check_requests(int exp_reqs);
    check_data("bus requests", be_q.size(), exp_reqs);
    check_flag("address increment", n_incr > 0, exp_reqs == 2);
  endtask

  task automatic store_and_check(lsu_type_e t, logic [31:0] addr, wd, int exp_reqs);
    logic [63:0] exp;
    logic [31:0] w0, rd;
    logic        v, le, se;
    int          n;
    w0  = {addr[31:2], 2'b00};
    exp = {mem_word(w0 + 4), mem_word(w0)};
    n   = (t == LSU_WORD) ? 4 : (t == LSU_HALF) ? 2 : 1;
    for (int j = 0; j < n; j++) exp[8*(addr[1:0] + j) +: 8] = wd[8*j +: 8];
    do_access(1'b1, t, addr, wd, 1'b0, rd, v, le, se);
    check_data("store low word", mem_word(w0), exp[31:0]);
    check_data("store high word", mem_word(w0 + 4), exp[63:32]);
    check_flag("store error", se, 1'b0);
    check_requests(exp_reqs);
  endtask

  task automatic load_and_check(lsu_type_e t, logic [31:0] addr, logic sx,
                                logic [31:0] exp, int exp_reqs);
    logic [31:0] rd;
    logic        v, le, se;
    do_access(1'b0, t, addr, '0, sx, rd, v, le, se);
    check_flag("load data valid", v, 1'b1);
    check_flag("load error", le, 1'b0);
    check_data("load data", rd, exp);
    check_requests(exp_reqs);
  endtask

  task automatic report_test(string name, int err0);
    $display("test %s finished, %0d errors", name, n_errors - err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_word_aligned();
    logic [31:0] wd;
    int          err0;
    err0 = n_errors;
    wd   = $urandom();
    store_and_check(LSU_WORD, 32'h100, wd, 1);
    check_data("aligned enables", be_q[0], 4'hF);
    load_and_check(LSU_WORD, 32'h100, 1'b0, wd, 1);
    check_data("aligned enables", be_q[0], 4'hF);
    report_test("word_aligned", err0);
  endtask

  task automatic test_byte_half();
    logic [31:0] wd, addr;
    lsu_type_e   t;
    int          err0;
    err0 = n_errors;
    for (int k = 0; k < 7; k++) begin  // bytes at 0..3 then halfwords at 0..2
      t      = (k < 4) ? LSU_BYTE : LSU_HALF;
      addr   = 32'h140 + ((k < 4) ? k : k - 4);
      wd     = $urandom();
      wd[7]  = k[0];                   // both signs on the top bit
      wd[15] = k[0];
      store_and_check(t, addr, wd, 1);
      load_and_check(t, addr, 1'b0, ext_expect(t, wd, 1'b0), 1);
      load_and_check(t, addr, 1'b1, ext_expect(t, wd, 1'b1), 1);
    end
    report_test("byte_half", err0);
  endtask

  task automatic test_word_split();
    logic [31:0] wd, addr;
    logic [3:0]  be_first, be_second;
    int          err0;
    err0 = n_errors;
    for (int off = 1; off < 4; off++) begin
      addr = 32'h200 + 16 * off + off;
      wd   = $urandom();
      for (int b = 0; b < 4; b++) begin
        be_first[b]  = (b >= off); // lanes k..3 of the first word
        be_second[b] = (b < off);  // lanes 0..k-1 of the next word
      end
      store_and_check(LSU_WORD, addr, wd, 2);
      check_data("first part enables", be_q[0], be_first);
      check_data("second part enables", be_q[1], be_second);
      load_and_check(LSU_WORD, addr, 1'b0, wd, 2);
    end
    report_test("word_split", err0);
  endtask

  task automatic test_half_split();
    logic [31:0] wd;
    int          err0;
    err0   = n_errors;
    wd     = $urandom();
    wd[15] = 1'b1;  // negative halfword
    store_and_check(LSU_HALF, 32'h2F3, wd, 2);
    check_data("second part enables", be_q[1], 4'h1);
    load_and_check(LSU_HALF, 32'h2F3, 1'b0, ext_expect(LSU_HALF, wd, 1'b0), 2);
    load_and_check(LSU_HALF, 32'h2F3, 1'b1, ext_expect(LSU_HALF, wd, 1'b1), 2);
    report_test("half_split", err0);
  endtask

  task automatic test_bus_error();
    logic [31:0] rd, addr;
    logic        v, le, se, we, second;
    int          err0;
    err0 = n_errors;
    for (int k = 0; k < 4; k++) begin
      we     = k[0];
      second = k[1];   // fault on the second part
      addr   = 32'h380 + 16 * k + 2;
      bad_q.delete();
      bad_q.push_back(second ? addr + 4 : addr);
      do_access(we, LSU_WORD, addr, $urandom(), 1'b0, rd, v, le, se);
      check_flag("load error", le, !we);
      check_flag("store error", se, we);
      check_flag("data valid on error", v, 1'b0);
      check_addr("failing address", addr_last_o, second ? addr + 4 : addr);
    end
    bad_q.delete();
    report_test("bus_error", err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: an access did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    void'($urandom(34));
    for (int i = 0; i < 1024; i++) mem[i] = i[7:0] ^ {4{i[9:8]}};
    repeat (10) @(posedge clk_i);
    rst_n <= 1'b1;
    @(posedge clk_i);
    check_flag("idle after reset", data_req_o | busy_o | addr_incr_req_o | lsu_resp_valid_o
               | lsu_rdata_valid_o | load_err_o | store_err_o, 1'b0);
    test_word_aligned();
    test_byte_half();
    test_word_split();
    test_half_split();
    test_bus_error();
    check_data("property failures", u_dut.u_ctrl.u_props.n_fail, '0);
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
hw/lsu_pkg.sv
hw/lsu_req_if.sv
hw/lsu_ctrl.sv
hw/lsu_wdata_align.sv
hw/lsu_rdata_align.sv
hw/lsu_top.sv
verification/lsu_props.sv
verification/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_req_if.sv
      - hw/lsu_ctrl.sv
      - hw/lsu_wdata_align.sv
      - hw/lsu_rdata_align.sv
      - hw/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/lsu_props.sv
      - verification/lsu_tb.sv
